//--- design/eth_types_pkg.sv
package eth_types_pkg;

  localparam logic [7:0] PROTO_ICMP = 8'd1; // IPv4 protocol number

  typedef logic [7:0]  byte_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] pkt_len_t;

  // One beat of a byte stream
  typedef struct packed {
    byte_t dat;
    logic  val;
    logic  sof; // First byte
    logic  eof; // Last byte
    logic  err;
  } stream_t;

  // Parsed IPv4 header fields
  typedef struct packed {
    ip_addr_t   src_ip;
    ip_addr_t   dst_ip;
    logic [7:0] proto;
    pkt_len_t   pld_len; // IPv4 payload bytes, ICMP header included
  } ipv4_meta_t;

endpackage

//--- design/icmp_pkg.sv
package icmp_pkg;

  localparam int ICMP_HDR_LEN = 8;  // Type, code, checksum, id, seq
  localparam int SLOT_BYTES   = 64; // Largest payload in one slot
  localparam int NUM_SLOTS    = 2;
  localparam int OFS_W        = $clog2(SLOT_BYTES);
  localparam int TX_CREDITS   = 4;  // Credits after reset

  localparam logic [7:0] ECHO_REQUEST = 8'd8;
  localparam logic [7:0] ECHO_REPLY   = 8'd0;

  typedef logic [$clog2(NUM_SLOTS)-1:0]        slot_t;
  typedef logic [$clog2(NUM_SLOTS)+OFS_W-1:0]  buf_addr_t; // Slot bit over byte offset
  typedef logic [$clog2(TX_CREDITS+1)-1:0]     credit_t;

  // Byte 0 on the wire sits in the top bits
  typedef struct packed {
    logic [7:0]  icmp_type;
    logic [7:0]  icmp_code;
    logic [15:0] icmp_cks;
    logic [15:0] icmp_id;
    logic [15:0] icmp_seq;
  } icmp_hdr_t;

  typedef struct packed {
    slot_t                     slot;
    eth_types_pkg::pkt_len_t   pld_len; // Echo data bytes after the header
    icmp_hdr_t                 hdr;     // Request header as received
    eth_types_pkg::ipv4_meta_t meta;
  } echo_desc_t;

  typedef struct packed {
    logic                 req;
    logic                 we;
    buf_addr_t            addr;
    eth_types_pkg::byte_t wdat;
  } buf_req_t;

endpackage

//--- design/echo_pld_ram.sv
`timescale 1ns/10ps

module echo_pld_ram (
  input  logic                 clk,
  input  icmp_pkg::buf_req_t   ram_req,
  output eth_types_pkg::byte_t rdat
);
  import eth_types_pkg::*;
  import icmp_pkg::*;

  byte_t mem [NUM_SLOTS*SLOT_BYTES]; // Slot 0 in the low half

  always_ff @(posedge clk) begin
    if (ram_req.req) begin
      if (ram_req.we) begin
        mem[ram_req.addr] <= ram_req.wdat;
      end else begin
        rdat <= mem[ram_req.addr]; // Valid the cycle after the grant
      end
    end
  end

endmodule

//--- design/echo_buf_arbiter.sv
`timescale 1ns/10ps

module echo_buf_arbiter (
  input  icmp_pkg::buf_req_t rx_req,
  input  icmp_pkg::buf_req_t tx_req,
  output logic               rx_gnt,
  output logic               tx_gnt,
  output icmp_pkg::buf_req_t ram_req
);

  // The receive stream cannot stall, so it always wins
  assign rx_gnt = rx_req.req;
  assign tx_gnt = tx_req.req && !rx_req.req; // Transmitter keeps asking until served

  always_comb begin
    if (rx_gnt) begin
      ram_req = rx_req;
    end else if (tx_gnt) begin
      ram_req = tx_req;
    end else begin
      ram_req = '0; // Idle port
    end
  end

endmodule

//--- design/icmp_rx.sv
`timescale 1ns/10ps

module icmp_rx (
  input  logic                      clk,
  input  logic                      fsm_rst,
  input  eth_types_pkg::stream_t    rx_strm,
  input  eth_types_pkg::ipv4_meta_t rx_meta,
  input  logic                      rx_gnt,
  input  logic                      slot_free,
  input  icmp_pkg::slot_t           slot_id,
  output icmp_pkg::buf_req_t        rx_req,
  output icmp_pkg::echo_desc_t      desc,
  output logic                      desc_val,
  output logic                      rx_drop
);
  import eth_types_pkg::*;
  import icmp_pkg::*;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_HEADER,
    RX_PAYLOAD,
    RX_DISCARD,
    RX_COMMIT
  } rx_state_t;

  rx_state_t            state;
  pkt_len_t             cnt;         // Bytes taken so far
  pkt_len_t             byte_num;
  logic                 bad;         // Sticky error of the current packet
  logic                 bad_nxt;
  logic                 ok_q;        // Verdict taken at eof
  logic [NUM_SLOTS-1:0] full;
  logic [NUM_SLOTS-1:0] full_eff;
  logic [NUM_SLOTS-1:0] commit_mask;
  logic [NUM_SLOTS-1:0] free_mask;
  slot_t                free_slot;
  slot_t                slot_q;
  ipv4_meta_t           meta_q;
  icmp_hdr_t            hdr_sr;
  icmp_hdr_t            hdr_nxt;
  logic                 start;
  logic                 accept;
  logic                 pass;
  logic                 hdr_last;
  logic                 type_bad;
  logic                 ovf;
  logic                 len_bad;
  logic                 wr_miss;
  logic                 wr_en;
  logic [OFS_W-1:0]     ofs;
  buf_addr_t            wr_addr;
  byte_t                wr_dat;

  // A new packet may start in the commit cycle of the previous one
  assign start = rx_strm.val && rx_strm.sof && (state == RX_IDLE || state == RX_COMMIT);

  assign wr_miss     = rx_req.req && !rx_gnt;
  assign pass        = state == RX_COMMIT && ok_q && !wr_miss;
  assign commit_mask = pass ? NUM_SLOTS'(1) << slot_q : '0;
  assign free_mask   = slot_free ? NUM_SLOTS'(1) << slot_id : '0;
  assign full_eff    = full | commit_mask; // Slot being committed counts as taken
  assign accept      = start && rx_meta.proto == PROTO_ICMP && !(&full_eff);

  always_comb begin
    free_slot = '0;
    for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
      if (!full_eff[i]) free_slot = slot_t'(i); // Lowest free one wins
    end
  end

  assign byte_num = cnt + 1'b1;
  assign hdr_nxt  = {hdr_sr[$bits(icmp_hdr_t)-9:0], rx_strm.dat};
  assign hdr_last = state == RX_HEADER && cnt == pkt_len_t'(ICMP_HDR_LEN - 1);
  assign type_bad = hdr_last &&
                    (hdr_nxt.icmp_type != ECHO_REQUEST || hdr_nxt.icmp_code != 8'd0);
  assign ovf      = state == RX_PAYLOAD && cnt >= pkt_len_t'(ICMP_HDR_LEN + SLOT_BYTES);
  assign bad_nxt  = bad || wr_miss || (rx_strm.val && (rx_strm.err || type_bad || ovf));
  assign len_bad  = byte_num != meta_q.pld_len || byte_num < pkt_len_t'(ICMP_HDR_LEN);
  assign ofs      = OFS_W'(cnt - pkt_len_t'(ICMP_HDR_LEN));

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state <= RX_IDLE;
      cnt   <= '0;
      bad   <= 1'b0;
      ok_q  <= 1'b0;
      full  <= '0;
      wr_en <= 1'b0;
    end else begin
      wr_en <= 1'b0;
      full  <= full_eff & ~free_mask;
      if (start) begin
        cnt <= pkt_len_t'(1);
        bad <= rx_strm.err;
        if (rx_strm.eof) begin
          state <= RX_COMMIT; // Too short to be ICMP
          ok_q  <= 1'b0;
        end else if (accept) begin
          state <= RX_HEADER;
        end else begin
          state <= RX_DISCARD; // Wrong protocol or no slot
        end
      end else begin
        case (state)
          RX_HEADER, RX_PAYLOAD: begin
            bad <= bad_nxt;
            if (rx_strm.val) begin
              cnt <= byte_num;
              if (state == RX_PAYLOAD && !ovf) wr_en <= 1'b1;
              if (hdr_last) state <= RX_PAYLOAD;
              if (rx_strm.eof) begin
                state <= RX_COMMIT;
                ok_q  <= !bad_nxt && !len_bad;
              end
            end
          end
          RX_DISCARD: begin
            if (rx_strm.val && rx_strm.eof) begin
              state <= RX_COMMIT;
              ok_q  <= 1'b0;
            end
          end
          RX_COMMIT: state <= RX_IDLE;
          default:   state <= RX_IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      meta_q <= rx_meta;
      slot_q <= free_slot;
    end
    if (start || (state == RX_HEADER && rx_strm.val)) hdr_sr <= hdr_nxt; // Header only
    wr_addr <= {slot_q, ofs};
    wr_dat  <= rx_strm.dat;
  end

  assign rx_req = '{req: wr_en, we: wr_en, addr: wr_addr, wdat: wr_dat};

  assign desc = '{slot:    slot_q,
                  pld_len: meta_q.pld_len - pkt_len_t'(ICMP_HDR_LEN),
                  hdr:     hdr_sr,
                  meta:    meta_q};

  assign desc_val = pass;
  assign rx_drop  = state == RX_COMMIT && !pass;

endmodule

//--- design/icmp_tx.sv
`timescale 1ns/10ps

module icmp_tx (
  input  logic                      clk,
  input  logic                      fsm_rst,
  input  icmp_pkg::echo_desc_t      desc,
  input  logic                      desc_val,
  input  logic                      tx_gnt,
  input  eth_types_pkg::byte_t      rdat,
  input  logic                      tx_credit,
  output icmp_pkg::buf_req_t        tx_req,
  output logic                      slot_free,
  output icmp_pkg::slot_t           slot_id,
  output eth_types_pkg::stream_t    tx_strm,
  output eth_types_pkg::ipv4_meta_t tx_meta
);
  import eth_types_pkg::*;
  import icmp_pkg::*;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_HEADER,
    TX_PLD_READ,
    TX_PLD_SEND,
    TX_DONE
  } tx_state_t;

  tx_state_t            state;
  echo_desc_t           q_mem [NUM_SLOTS];
  logic [NUM_SLOTS-1:0] q_vld;
  slot_t                wr_ptr;
  slot_t                rd_ptr;
  echo_desc_t           head;
  credit_t              credits;
  pkt_len_t             cnt;      // Header byte or payload offset
  icmp_hdr_t            rep_hdr;
  logic [16:0]          cks_sum;
  byte_t                hdr_byte;
  logic                 hdr_end;
  logic                 pld_end;
  logic                 hdr_fire;
  logic                 pld_fire;
  logic                 last_beat;
  logic                 rd_req;
  logic                 beat_val;
  logic                 beat_sof;
  logic                 beat_eof;
  byte_t                beat_dat;

  assign head = q_mem[rd_ptr]; // Oldest stored request

  // Type 8 to 0 lowers the summed word by 0x0800, the checksum rises by the same
  assign cks_sum = {1'b0, head.hdr.icmp_cks} + {1'b0, ECHO_REQUEST - ECHO_REPLY, 8'h00};

  always_comb begin
    rep_hdr           = head.hdr;
    rep_hdr.icmp_type = ECHO_REPLY;
    rep_hdr.icmp_cks  = cks_sum[15:0] + 16'(cks_sum[16]); // End-around carry
  end

  assign hdr_byte  = rep_hdr[8*(ICMP_HDR_LEN - 1 - int'(cnt[2:0])) +: 8];
  assign hdr_end   = cnt == pkt_len_t'(ICMP_HDR_LEN - 1);
  assign pld_end   = cnt == head.pld_len - 1'b1;
  assign hdr_fire  = state == TX_HEADER && credits != '0;
  assign pld_fire  = state == TX_PLD_SEND; // Credit checked before the read
  assign last_beat = (hdr_fire && hdr_end && head.pld_len == '0) || (pld_fire && pld_end);

  // Read only with a credit in hand so the byte can leave right away
  assign rd_req = state == TX_PLD_READ && credits != '0;
  assign tx_req = '{req: rd_req, we: 1'b0, addr: {head.slot, cnt[OFS_W-1:0]}, wdat: '0};

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state    <= TX_IDLE;
      cnt      <= '0;
      credits  <= credit_t'(TX_CREDITS);
      q_vld    <= '0;
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      beat_val <= 1'b0;
      beat_sof <= 1'b0;
      beat_eof <= 1'b0;
    end else begin
      beat_val <= hdr_fire || pld_fire;
      beat_sof <= hdr_fire && cnt == '0;
      beat_eof <= last_beat;

      case ({tx_credit, hdr_fire || pld_fire})
        2'b10:   if (credits != credit_t'(TX_CREDITS)) credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits; // Returned and spent together
      endcase

      if (desc_val) begin
        q_vld[wr_ptr] <= 1'b1;
        wr_ptr        <= wr_ptr + 1'b1;
      end
      if (state == TX_DONE) begin
        q_vld[rd_ptr] <= 1'b0;
        rd_ptr        <= rd_ptr + 1'b1;
      end

      case (state)
        TX_IDLE: begin
          cnt <= '0;
          if (q_vld[rd_ptr]) state <= TX_HEADER;
        end
        TX_HEADER: begin
          if (hdr_fire) begin
            if (hdr_end) begin
              cnt   <= '0;
              state <= (head.pld_len == '0) ? TX_DONE : TX_PLD_READ;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        TX_PLD_READ: if (tx_gnt) state <= TX_PLD_SEND;
        TX_PLD_SEND: begin
          cnt   <= cnt + 1'b1;
          state <= pld_end ? TX_DONE : TX_PLD_READ;
        end
        TX_DONE: state <= TX_IDLE;
        default: state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (desc_val) q_mem[wr_ptr] <= desc;
    beat_dat <= hdr_fire ? hdr_byte : rdat;
  end

  assign tx_strm = '{dat: beat_dat, val: beat_val, sof: beat_sof, eof: beat_eof, err: 1'b0};

  // Head entry stays put until the eof beat is out
  assign tx_meta = '{src_ip:  head.meta.dst_ip,
                     dst_ip:  head.meta.src_ip,
                     proto:   head.meta.proto,
                     pld_len: head.meta.pld_len};

  assign slot_free = state == TX_DONE;
  assign slot_id   = head.slot;

endmodule

//--- design/icmp_echo_top.sv
`timescale 1ns/10ps

module icmp_echo_top (
  input  logic                      clk,
  input  logic                      fsm_rst,
  input  eth_types_pkg::stream_t    rx_strm,
  input  eth_types_pkg::ipv4_meta_t rx_meta,
  input  logic                      tx_credit,
  output eth_types_pkg::stream_t    tx_strm,
  output eth_types_pkg::ipv4_meta_t tx_meta,
  output logic                      rx_drop
);
  import eth_types_pkg::*;
  import icmp_pkg::*;

  buf_req_t   rx_req;
  buf_req_t   tx_req;
  buf_req_t   ram_req;
  logic       rx_gnt;
  logic       tx_gnt;
  byte_t      rdat;
  echo_desc_t desc;
  logic       desc_val;
  logic       slot_free;
  slot_t      slot_id;

  icmp_rx i_icmp_rx (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .rx_strm   (rx_strm),
    .rx_meta   (rx_meta),
    .rx_gnt    (rx_gnt),
    .slot_free (slot_free),
    .slot_id   (slot_id),
    .rx_req    (rx_req),
    .desc      (desc),
    .desc_val  (desc_val),
    .rx_drop   (rx_drop)
  );

  echo_buf_arbiter i_echo_buf_arbiter (
    .rx_req  (rx_req),
    .tx_req  (tx_req),
    .rx_gnt  (rx_gnt),
    .tx_gnt  (tx_gnt),
    .ram_req (ram_req)
  );

  echo_pld_ram i_echo_pld_ram (
    .clk     (clk),
    .ram_req (ram_req),
    .rdat    (rdat)
  );

  icmp_tx i_icmp_tx (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .desc      (desc),
    .desc_val  (desc_val),
    .tx_gnt    (tx_gnt),
    .rdat      (rdat),
    .tx_credit (tx_credit),
    .tx_req    (tx_req),
    .slot_free (slot_free),
    .slot_id   (slot_id),
    .tx_strm   (tx_strm),
    .tx_meta   (tx_meta)
  );

endmodule

//--- testbench/icmp_echo_tasks.svh
task automatic compare(input string name, input logic [31:0] exp_v, input logic [31:0] got_v);
  assert (got_v === exp_v) else begin
    err_cnt++;
    $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp_v, got_v);
  end
endtask

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16+x^14+x^13+x^11
endfunction

function automatic byte_t rand_byte();
  byte_t b;
  for (int i = 0; i < 8; i++) begin
    lfsr = lfsr_next(lfsr);
    b    = {b[6:0], lfsr[0]};
  end
  return b;
endfunction

// Type 8 to 0 raises the checksum by 0x0800 with end-around carry
function automatic logic [15:0] reply_cks(input logic [15:0] cks);
  logic [16:0] s;
  s = {1'b0, cks} + 17'h00800;
  return s[15:0] + {15'd0, s[16]};
endfunction

task automatic build_pkt(input byte_t typ, input byte_t code, input logic [15:0] cks,
                         input int pld_n);
  pkt.delete();
  pkt.push_back(typ);
  pkt.push_back(code);
  pkt.push_back(cks[15:8]);
  pkt.push_back(cks[7:0]);
  repeat (4 + pld_n) pkt.push_back(rand_byte()); // Id, seq, then echo data
endtask

function automatic ipv4_meta_t make_meta(input byte_t proto, input int len);
  return '{src_ip: {8'd10, 16'd0, rand_byte()}, dst_ip: {8'd192, 16'd168, rand_byte()},
           proto: proto, pld_len: pkt_len_t'(len)};
endfunction

task automatic expect_reply(input ipv4_meta_t m);
  logic [15:0] cks;
  cks = reply_cks({pkt[2], pkt[3]});
  exp_dat.push_back(ECHO_REPLY);
  exp_dat.push_back(pkt[1]);
  exp_dat.push_back(cks[15:8]);
  exp_dat.push_back(cks[7:0]);
  for (int i = 4; i < pkt.size(); i++) exp_dat.push_back(pkt[i]);
  exp_len.push_back(pkt.size());
  exp_meta.push_back('{src_ip: m.dst_ip, dst_ip: m.src_ip, proto: m.proto, pld_len: m.pld_len});
  exp_replies++;
endtask

task automatic drive_pkt(input ipv4_meta_t m, input int err_at);
  for (int i = 0; i < pkt.size(); i++) begin
    @(posedge clk);
    #1;
    rx_meta = m;
    rx_strm = '{dat: pkt[i], val: 1'b1, sof: i == 0, eof: i == pkt.size() - 1, err: i == err_at};
  end
endtask

task automatic rx_idle();
  @(posedge clk);
  #1;
  rx_strm = '0;
  rx_meta = '0;
endtask

task automatic send_echo(input logic [15:0] cks, input int pld_n, input bit idle_after);
  ipv4_meta_t m;
  build_pkt(ECHO_REQUEST, 8'd0, cks, pld_n);
  m = make_meta(PROTO_ICMP, pkt.size());
  expect_reply(m);
  drive_pkt(m, -1);
  if (idle_after) rx_idle();
endtask

// A request that must be dropped with one rx_drop pulse
task automatic send_bad(input byte_t proto, input byte_t typ, input byte_t code,
                        input int len_adj, input int err_at, input int pld_n);
  ipv4_meta_t m;
  build_pkt(typ, code, {rand_byte(), rand_byte()}, pld_n);
  m = make_meta(proto, pkt.size() + len_adj);
  drive_pkt(m, err_at);
  rx_idle();
  exp_drops++;
  while (drop_cnt < exp_drops) @(posedge clk);
  repeat (4) @(posedge clk);
  compare("rx_drop pulses", exp_drops, drop_cnt);
endtask

task automatic check_replies();
  int         len;
  int         missing;
  byte_t      e;
  ipv4_meta_t em;
  ipv4_meta_t gm;
  while (n_replies < exp_replies) @(posedge clk);
  while (exp_len.size() > 0) begin
    len     = exp_len.pop_front();
    em      = exp_meta.pop_front();
    gm      = got_meta.pop_front();
    missing = 0;
    compare("tx_meta.src_ip", em.src_ip, gm.src_ip);
    compare("tx_meta.dst_ip", em.dst_ip, gm.dst_ip);
    compare("tx_meta.proto", em.proto, gm.proto);
    compare("tx_meta.pld_len", em.pld_len, gm.pld_len);
    for (int i = 0; i < len; i++) begin
      e = exp_dat.pop_front();
      if (got_dat.size() == 0) begin
        missing++;
      end else begin
        compare("tx_strm.dat", e, got_dat.pop_front());
        compare("tx_strm.sof", i == 0, got_sof.pop_front());
        compare("tx_strm.eof", i == len - 1, got_eof.pop_front());
      end
    end
    assert (missing == 0) else begin
      err_cnt++;
      $display("Reply at %0t is %0d beats short", $time, missing);
    end
  end
endtask

task automatic set_credit_hold(input logic hold);
  if (hold) begin
    while (owed != 0) @(posedge clk); // Let returned credits settle first
  end
  @(negedge clk);
  credit_hold = hold;
endtask

task automatic test_single_echo();
  send_echo({rand_byte(), rand_byte()}, 20, 1'b1);
  check_replies();
endtask

task automatic test_cks_carry();
  send_echo(16'hF800, 10, 1'b1);
  send_echo(16'hFFFF, 0, 1'b1);
  check_replies();
endtask

task automatic test_non_echo();
  send_bad(8'd6, ECHO_REQUEST, 8'd0, 0, -1, 12); // TCP
  send_bad(PROTO_ICMP, ECHO_REPLY, 8'd0, 0, -1, 12);
  send_bad(PROTO_ICMP, ECHO_REQUEST, 8'd1, 0, -1, 12);
endtask

task automatic test_bad_length();
  send_bad(PROTO_ICMP, ECHO_REQUEST, 8'd0, 1, -1, 16);
  send_bad(PROTO_ICMP, ECHO_REQUEST, 8'd0, 0, 10, 16);
  send_bad(PROTO_ICMP, ECHO_REQUEST, 8'd0, 0, -1, SLOT_BYTES + 1);
endtask

task automatic test_credit_pause();
  set_credit_hold(1'b1);
  send_echo({rand_byte(), rand_byte()}, 30, 1'b1);
  repeat (60) @(posedge clk);
  assert (got_dat.size() <= TX_CREDITS) else begin
    err_cnt++;
    $display("CHECK FAILED at %0t: tx_strm beats while paused expected at most %0d got %0d",
             $time, TX_CREDITS, got_dat.size());
  end
  set_credit_hold(1'b0);
  check_replies();
endtask

task automatic test_two_and_full();
  send_echo({rand_byte(), rand_byte()}, 12, 1'b0); // Second sof right after this eof
  send_echo({rand_byte(), rand_byte()}, 40, 1'b1);
  check_replies();
  set_credit_hold(1'b1);
  send_echo({rand_byte(), rand_byte()}, 16, 1'b1);
  send_echo({rand_byte(), rand_byte()}, 16, 1'b1);
  repeat (2) @(posedge clk);
  send_bad(PROTO_ICMP, ECHO_REQUEST, 8'd0, 0, -1, 16); // Both slots still held
  set_credit_hold(1'b0);
  check_replies();
endtask

//--- testbench/icmp_echo_tb.sv
`timescale 1ns/10ps

module icmp_echo_tb;
  import eth_types_pkg::*;
  import icmp_pkg::*;

  localparam int TIMEOUT_CYCLES = 20000; // The six tests take a few thousand cycles

  logic       clk = 1'b0;
  logic       fsm_rst;
  stream_t    rx_strm;
  ipv4_meta_t rx_meta;
  logic       tx_credit;
  stream_t    tx_strm;
  ipv4_meta_t tx_meta;
  logic       rx_drop;

  byte_t      pkt[$];      // Request being built
  byte_t      exp_dat[$];
  int         exp_len[$];
  ipv4_meta_t exp_meta[$];
  byte_t      got_dat[$];
  logic       got_sof[$];
  logic       got_eof[$];
  ipv4_meta_t got_meta[$];
  int         n_replies = 0;
  int         exp_replies = 0;
  int         drop_cnt = 0;
  int         exp_drops = 0;
  int         owed = 0;    // Beats seen but not yet credited
  int         err_cnt = 0;
  int         cycle_cnt = 0;
  logic       credit_hold = 1'b0;
  logic [15:0] lfsr = 16'd62738;

  icmp_echo_top i_icmp_echo_top (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .rx_strm   (rx_strm),
    .rx_meta   (rx_meta),
    .tx_credit (tx_credit),
    .tx_strm   (tx_strm),
    .tx_meta   (tx_meta),
    .rx_drop   (rx_drop)
  );

  always #4 clk = ~clk;

  `include "icmp_echo_tasks.svh"

  // Reply monitor sampled mid cycle
  always @(negedge clk) begin
    if (!fsm_rst) begin
      if (tx_strm.val) begin
        compare("tx_strm.err", 1'b0, tx_strm.err);
        got_dat.push_back(tx_strm.dat);
        got_sof.push_back(tx_strm.sof);
        got_eof.push_back(tx_strm.eof);
        if (tx_strm.sof) got_meta.push_back(tx_meta);
        if (tx_strm.eof) n_replies++;
        owed++;
      end
      if (rx_drop) drop_cnt++;
    end
  end

  // One credit back per consumed beat unless paused
  always @(posedge clk) begin
    #1;
    if (owed > 0 && !credit_hold) begin
      tx_credit = 1'b1;
      owed--;
    end else begin
      tx_credit = 1'b0;
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a reply or drop never arrived", cycle_cnt);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial begin
    rx_strm   = '0;
    rx_meta   = '0;
    tx_credit = 1'b0;
    fsm_rst   = 1'b1;
    repeat (5) @(posedge clk);
    #1 fsm_rst = 1'b0;
    repeat (3) @(posedge clk);
    test_single_echo();
    test_cks_carry();
    test_non_echo();
    test_bad_length();
    test_credit_pause();
    test_two_and_full();
    repeat (50) @(posedge clk);
    compare("reply count", exp_replies, n_replies);
    compare("rx_drop pulses", exp_drops, drop_cnt);
    assert (got_dat.size() == 0) else begin
      err_cnt++;
      $display("Reply beats arrived that no request asked for: %0d", got_dat.size());
    end
    $display("Errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+testbench
design/eth_types_pkg.sv
design/icmp_pkg.sv
design/echo_pld_ram.sv
design/echo_buf_arbiter.sv
design/icmp_rx.sv
design/icmp_tx.sv
design/icmp_echo_top.sv
testbench/icmp_echo_tb.sv
